/* common/eth_tx_pkg.sv */
// shared widths, header/beat/register types and the register map for the transmit framer
package eth_tx_pkg;

    localparam int data_width = 64;
    localparam int keep_width = data_width / 8;
    localparam int eth_hdr_bytes = 14;

    // header spills past the first beat, so each input beat splits in two
    localparam int carry_bytes = 2 * keep_width - eth_hdr_bytes;
    localparam int save_bytes = keep_width - carry_bytes;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    typedef struct packed {
        logic [data_width-1:0] tdata;
        logic [keep_width-1:0] tkeep;
        logic                  tlast;
        logic                  tuser;
    } axis_beat_t;

    typedef logic [1:0] cfg_addr_t;
    typedef logic [31:0] cfg_word_t;

    // register map
    localparam cfg_addr_t reg_ctrl = 2'd0;
    localparam cfg_addr_t reg_mac_hi = 2'd1;
    localparam cfg_addr_t reg_mac_lo = 2'd2;
    localparam cfg_addr_t reg_frame_count = 2'd3;

endpackage

/* common/axis_if.sv */
// 64-bit byte-keyed stream bundle, connected through the src and dst modports
`timescale 1ns/1ps

interface axis_if import eth_tx_pkg::*; ();

    logic [data_width-1:0] tdata;
    logic [keep_width-1:0] tkeep;
    logic                  tvalid;
    logic                  tready;
    logic                  tlast;
    logic                  tuser;

    // driving side
    modport src (
        output tdata, tkeep, tvalid, tlast, tuser,
        input  tready
    );

    // receiving side
    modport dst (
        input  tdata, tkeep, tvalid, tlast, tuser,
        output tready
    );

endinterface

/* verilog/reg_slice.sv */
// two-entry valid/ready register slice with registered ready, for any packed payload type
`timescale 1ns/1ps

module reg_slice #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    logic ready_reg;
    logic ready_early;
    logic out_valid_reg;
    logic out_valid_next;
    logic temp_valid_reg;
    logic temp_valid_next;
    T     out_reg;
    T     temp_reg;
    logic in_to_out;
    logic in_to_temp;
    logic temp_to_out;

    assign in_ready = ready_reg;
    assign out_data = out_reg;
    assign out_valid = out_valid_reg;

    // stay ready unless the temp entry could fill this cycle
    assign ready_early = out_ready || (!temp_valid_reg && (!out_valid_reg || !in_valid));

    always_comb begin
        out_valid_next = out_valid_reg;
        temp_valid_next = temp_valid_reg;
        in_to_out = 1'b0;
        in_to_temp = 1'b0;
        temp_to_out = 1'b0;
        if (ready_reg) begin
            if (out_ready || !out_valid_reg) begin
                out_valid_next = in_valid;
                in_to_out = 1'b1;
            end else begin
                // output stalled, park the item
                temp_valid_next = in_valid;
                in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = temp_valid_reg;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg <= 1'b0;
            out_valid_reg <= 1'b0;
            temp_valid_reg <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            out_valid_reg <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            out_reg <= in_data;
        end else if (temp_to_out) begin
            out_reg <= temp_reg;
        end
        if (in_to_temp) begin
            temp_reg <= in_data;
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_data)
    ) else $error("reg_slice output changed while stalled");

endmodule

/* eth_tx/eth_hdr_insert.sv */
// builds an Ethernet frame by putting the 14-byte header in front of the shifted payload stream
`timescale 1ns/1ps

module eth_hdr_insert import eth_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  eth_hdr_t    hdr,
    input  logic        hdr_valid,
    output logic        hdr_ready,
    input  logic [47:0] src_mac,
    input  logic        tx_enable,
    axis_if.dst         payload,
    axis_if.src         frame,
    output logic        frame_done,
    output logic        busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_header,
        st_header_last,
        st_payload
    } state_t;

    state_t state;

    eth_hdr_t    hdr_reg;
    logic [47:0] src_reg;

    // upper part of the previous input beat, still to be sent
    logic [data_width-1:0] save_data;
    logic [keep_width-1:0] save_keep;
    logic                  save_user;
    logic                  flush_pending;

    logic [47:0] dest_le;
    logic [47:0] src_le;
    logic [15:0] type_le;
    logic        pay_xfer;
    logic        extra_bytes;

    logic [data_width-1:0] out_data;
    logic [keep_width-1:0] out_keep;
    logic                  out_valid;
    logic                  out_last;
    logic                  out_user;
    logic                  pay_ready;

    // wire order puts the most significant byte in byte lane 0
    assign dest_le = {<<8{hdr_reg.dest_mac}};
    assign src_le = {<<8{src_reg}};
    assign type_le = {<<8{hdr_reg.eth_type}};

    assign hdr_ready = (state == st_idle) && tx_enable;
    assign pay_xfer = payload.tvalid && payload.tready;
    // last beat has bytes that spill into a flush beat
    assign extra_bytes = |payload.tkeep[keep_width-1:carry_bytes];

    always_comb begin
        out_data = '0;
        out_keep = '0;
        out_valid = 1'b0;
        out_last = 1'b0;
        out_user = 1'b0;
        pay_ready = 1'b0;
        case (state)
            st_header: begin
                out_data = {src_le[15:0], dest_le};
                out_keep = '1;
                out_valid = 1'b1;
            end
            st_header_last: begin
                out_data = {payload.tdata[8*carry_bytes-1:0], type_le, src_le[47:16]};
                out_keep = {payload.tkeep[carry_bytes-1:0], {save_bytes{1'b1}}};
                out_valid = payload.tvalid;
                out_last = payload.tlast && !extra_bytes;
                out_user = payload.tuser && out_last;
                pay_ready = frame.tready;
            end
            st_payload: begin
                if (flush_pending) begin
                    out_data = {{8*carry_bytes{1'b0}}, save_data[data_width-1:8*carry_bytes]};
                    out_keep = {{carry_bytes{1'b0}}, save_keep[keep_width-1:carry_bytes]};
                    out_valid = 1'b1;
                    out_last = 1'b1;
                    out_user = save_user;
                end else begin
                    out_data = {payload.tdata[8*carry_bytes-1:0],
                                save_data[data_width-1:8*carry_bytes]};
                    out_keep = {payload.tkeep[carry_bytes-1:0],
                                save_keep[keep_width-1:carry_bytes]};
                    out_valid = payload.tvalid;
                    out_last = payload.tlast && !extra_bytes;
                    out_user = payload.tuser && out_last;
                    pay_ready = frame.tready;
                end
            end
            default: begin
                out_valid = 1'b0;
            end
        endcase
    end

    assign frame.tdata = out_data;
    assign frame.tkeep = out_keep;
    assign frame.tvalid = out_valid;
    assign frame.tlast = out_last;
    assign frame.tuser = out_user;
    assign payload.tready = pay_ready;

    assign frame_done = frame.tvalid && frame.tready && frame.tlast;
    assign busy = (state != st_idle);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            flush_pending <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (hdr_valid && hdr_ready) begin
                        state <= st_header;
                    end
                end
                st_header: begin
                    if (frame.tready) begin
                        state <= st_header_last;
                    end
                end
                st_header_last: begin
                    if (pay_xfer) begin
                        if (payload.tlast && !extra_bytes) begin
                            state <= st_idle;
                        end else begin
                            state <= st_payload;
                            flush_pending <= payload.tlast;
                        end
                    end
                end
                st_payload: begin
                    if (flush_pending) begin
                        if (frame.tready) begin
                            state <= st_idle;
                            flush_pending <= 1'b0;
                        end
                    end else if (pay_xfer && payload.tlast) begin
                        if (extra_bytes) begin
                            flush_pending <= 1'b1;
                        end else begin
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // header fields and source MAC latched together at acceptance
    always_ff @(posedge clk) begin
        if (hdr_valid && hdr_ready) begin
            hdr_reg <= hdr;
            src_reg <= src_mac;
        end
        if (pay_xfer) begin
            save_data <= payload.tdata;
            save_keep <= payload.tkeep;
            save_user <= payload.tuser;
        end
    end

    a_keep_contiguous: assert property (
        @(posedge clk) disable iff (rst)
        frame.tvalid |-> (frame.tkeep != '0) && ((frame.tkeep & (frame.tkeep + 1'b1)) == '0)
    ) else $error("frame tkeep not contiguous from bit 0");

endmodule

/* eth_tx/tx_cfg_regs.sv */
// control and status registers that hold the source MAC, gate new frames and count sent frames
`timescale 1ns/1ps

module tx_cfg_regs import eth_tx_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cfg_addr_t   cfg_addr,
    input  cfg_word_t   cfg_wdata,
    input  logic        cfg_we,
    output cfg_word_t   cfg_rdata,
    input  logic        frame_done,
    output logic [47:0] src_mac,
    output logic        tx_enable
);

    logic        enable_reg;
    logic [47:0] mac_reg;
    cfg_word_t   frame_count;

    assign src_mac = mac_reg;
    assign tx_enable = enable_reg;

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_reg <= 1'b0;
            mac_reg <= '0;
            frame_count <= '0;
        end else begin
            if (cfg_we) begin
                case (cfg_addr)
                    reg_ctrl: enable_reg <= cfg_wdata[0];
                    reg_mac_hi: mac_reg[47:32] <= cfg_wdata[15:0];
                    reg_mac_lo: mac_reg[31:0] <= cfg_wdata;
                    // count is read only
                    default: begin
                        mac_reg <= mac_reg;
                    end
                endcase
            end
            // wraps at 2^32
            if (frame_done) begin
                frame_count <= frame_count + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            reg_ctrl: cfg_rdata = {31'd0, enable_reg};
            reg_mac_hi: cfg_rdata = {16'd0, mac_reg[47:32]};
            reg_mac_lo: cfg_rdata = mac_reg[31:0];
            reg_frame_count: cfg_rdata = frame_count;
            default: cfg_rdata = '0;
        endcase
    end

endmodule

/* verilog/eth_tx_top.sv */
// transmit framer top level with header and output register slices and the config block
`timescale 1ns/1ps

module eth_tx_top import eth_tx_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // header channel
    input  logic                  hdr_valid,
    output logic                  hdr_ready,
    input  logic [47:0]           hdr_dest_mac,
    input  logic [15:0]           hdr_eth_type,

    // payload stream
    input  logic [data_width-1:0] s_tdata,
    input  logic [keep_width-1:0] s_tkeep,
    input  logic                  s_tvalid,
    output logic                  s_tready,
    input  logic                  s_tlast,
    input  logic                  s_tuser,

    // frame stream
    output logic [data_width-1:0] m_tdata,
    output logic [keep_width-1:0] m_tkeep,
    output logic                  m_tvalid,
    input  logic                  m_tready,
    output logic                  m_tlast,
    output logic                  m_tuser,

    // register access
    input  cfg_addr_t             cfg_addr,
    input  cfg_word_t             cfg_wdata,
    input  logic                  cfg_we,
    output cfg_word_t             cfg_rdata,

    output logic                  busy
);

    eth_hdr_t    hdr_in;
    eth_hdr_t    hdr_buf;
    logic        hdr_buf_valid;
    logic        hdr_buf_ready;
    logic        hdr_slice_ready;
    logic        tx_enable;
    logic [47:0] src_mac;
    logic        frame_done;
    axis_beat_t  frame_beat;
    axis_beat_t  m_beat;

    axis_if payload_bus ();
    axis_if frame_bus ();

    assign hdr_in = '{dest_mac: hdr_dest_mac, eth_type: hdr_eth_type};
    // no header is taken in while transmit is disabled
    assign hdr_ready = hdr_slice_ready && tx_enable;

    reg_slice #(.T(eth_hdr_t)) hdr_slice (
        .clk       (clk),
        .rst       (rst),
        .in_data   (hdr_in),
        .in_valid  (hdr_valid && tx_enable),
        .in_ready  (hdr_slice_ready),
        .out_data  (hdr_buf),
        .out_valid (hdr_buf_valid),
        .out_ready (hdr_buf_ready)
    );

    assign payload_bus.tdata = s_tdata;
    assign payload_bus.tkeep = s_tkeep;
    assign payload_bus.tvalid = s_tvalid;
    assign payload_bus.tlast = s_tlast;
    assign payload_bus.tuser = s_tuser;
    assign s_tready = payload_bus.tready;

    eth_hdr_insert eth_hdr_insert_inst (
        .clk        (clk),
        .rst        (rst),
        .hdr        (hdr_buf),
        .hdr_valid  (hdr_buf_valid),
        .hdr_ready  (hdr_buf_ready),
        .src_mac    (src_mac),
        .tx_enable  (tx_enable),
        .payload    (payload_bus.dst),
        .frame      (frame_bus.src),
        .frame_done (frame_done),
        .busy       (busy)
    );

    assign frame_beat = '{tdata: frame_bus.tdata, tkeep: frame_bus.tkeep,
                          tlast: frame_bus.tlast, tuser: frame_bus.tuser};

    reg_slice #(.T(axis_beat_t)) out_slice (
        .clk       (clk),
        .rst       (rst),
        .in_data   (frame_beat),
        .in_valid  (frame_bus.tvalid),
        .in_ready  (frame_bus.tready),
        .out_data  (m_beat),
        .out_valid (m_tvalid),
        .out_ready (m_tready)
    );

    assign m_tdata = m_beat.tdata;
    assign m_tkeep = m_beat.tkeep;
    assign m_tlast = m_beat.tlast;
    assign m_tuser = m_beat.tuser;

    tx_cfg_regs tx_cfg_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_we     (cfg_we),
        .cfg_rdata  (cfg_rdata),
        .frame_done (frame_done),
        .src_mac    (src_mac),
        .tx_enable  (tx_enable)
    );

endmodule

/* testbench/tb_eth_tx.sv */
// directed testbench for the Ethernet transmit framer top, compiled from build.f
`timescale 1ns/1ps

module tb_eth_tx import eth_tx_pkg::*; ();

    // input and output beats of all tests rounded up
    localparam int total_test_beats = 150;
    localparam int timeout_cycles = total_test_beats * 20 + 500;

    logic                  clk;
    logic                  rst;
    logic                  hdr_valid;
    logic                  hdr_ready;
    logic [47:0]           hdr_dest_mac;
    logic [15:0]           hdr_eth_type;
    logic [data_width-1:0] s_tdata;
    logic [keep_width-1:0] s_tkeep;
    logic                  s_tvalid;
    logic                  s_tready;
    logic                  s_tlast;
    logic                  s_tuser;
    logic [data_width-1:0] m_tdata;
    logic [keep_width-1:0] m_tkeep;
    logic                  m_tvalid;
    logic                  m_tready;
    logic                  m_tlast;
    logic                  m_tuser;
    cfg_addr_t             cfg_addr;
    cfg_word_t             cfg_wdata;
    logic                  cfg_we;
    cfg_word_t             cfg_rdata;
    logic                  busy;

    int          errors;
    int          cycle_count;
    int          frames_sent;
    logic [47:0] src_mac_model;
    cfg_word_t   rd;

    // frames of the current test with payload bytes kept flat in arrival order
    eth_hdr_t   hdr_list[$];
    int         len_list[$];
    bit         bad_list[$];
    logic [7:0] pay_bytes[$];

    eth_tx_top eth_tx_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("simulation stopped after %0d cycles, a transfer never completed", cycle_count);
        $display("Some tests failed");
        $finish;
    end

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input cfg_word_t got, input cfg_word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
        if (got.tdata !== exp.tdata) begin
            $display("FAILED %s m_tdata: got %h, expected %h", name, got.tdata, exp.tdata);
            errors++;
        end
        if (got.tkeep !== exp.tkeep) begin
            $display("FAILED %s m_tkeep: got %h, expected %h", name, got.tkeep, exp.tkeep);
            errors++;
        end
        if (got.tlast !== exp.tlast) begin
            $display("FAILED %s m_tlast: got %h, expected %h", name, got.tlast, exp.tlast);
            errors++;
        end
        if (got.tuser !== exp.tuser) begin
            $display("FAILED %s m_tuser: got %h, expected %h", name, got.tuser, exp.tuser);
            errors++;
        end
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input cfg_word_t data);
        @(negedge clk);
        cfg_addr = addr;
        cfg_wdata = data;
        cfg_we = 1'b1;
        @(negedge clk);
        cfg_we = 1'b0;
        if (addr == reg_mac_hi) begin
            src_mac_model[47:32] = data[15:0];
        end else if (addr == reg_mac_lo) begin
            src_mac_model[31:0] = data;
        end
    endtask

    task automatic cfg_read(input cfg_addr_t addr, output cfg_word_t data);
        @(negedge clk);
        cfg_addr = addr;
        cfg_we = 1'b0;
        #1;
        data = cfg_rdata;
    endtask

    task automatic add_frame(input logic [47:0] dest, input logic [15:0] etype,
                             input int len, input bit bad);
        eth_hdr_t h;
        h.dest_mac = dest;
        h.eth_type = etype;
        hdr_list.push_back(h);
        len_list.push_back(len);
        bad_list.push_back(bad);
        repeat (len) pay_bytes.push_back(8'($urandom));
    endtask

    task automatic clear_frames();
        hdr_list.delete();
        len_list.delete();
        bad_list.delete();
        pay_bytes.delete();
    endtask

    function automatic int payload_offset(input int idx);
        int sum;
        sum = 0;
        for (int i = 0; i < idx; i++) begin
            sum += len_list[i];
        end
        return sum;
    endfunction

    task automatic send_frame(input int idx);
        int len;
        int nbeats;
        int offset;
        int pos;
        len = len_list[idx];
        nbeats = (len + keep_width - 1) / keep_width;
        offset = payload_offset(idx);
        @(negedge clk);
        hdr_dest_mac = hdr_list[idx].dest_mac;
        hdr_eth_type = hdr_list[idx].eth_type;
        hdr_valid = 1'b1;
        #1;
        while (!hdr_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        hdr_valid = 1'b0;
        for (int b = 0; b < nbeats; b++) begin
            for (int k = 0; k < keep_width; k++) begin
                pos = keep_width * b + k;
                // lanes past the end carry junk with keep low
                s_tdata[8*k +: 8] = (pos < len) ? pay_bytes[offset + pos] : 8'($urandom);
                s_tkeep[k] = (pos < len);
            end
            s_tlast = (b == nbeats - 1);
            s_tuser = s_tlast && bad_list[idx];
            s_tvalid = 1'b1;
            #1;
            while (!s_tready) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
    endtask

    task automatic expect_frame(input int idx, input bit backpressure);
        logic [7:0] exp_q[$];
        axis_beat_t got;
        axis_beat_t exp;
        int         offset;
        int         pos;
        int         beats;
        int         exp_beats;
        bit         done;
        offset = payload_offset(idx);
        // dest, source and type in wire order, then the payload
        for (int i = 5; i >= 0; i--) begin
            exp_q.push_back(hdr_list[idx].dest_mac[8*i +: 8]);
        end
        for (int i = 5; i >= 0; i--) begin
            exp_q.push_back(src_mac_model[8*i +: 8]);
        end
        exp_q.push_back(hdr_list[idx].eth_type[15:8]);
        exp_q.push_back(hdr_list[idx].eth_type[7:0]);
        for (int i = 0; i < len_list[idx]; i++) begin
            exp_q.push_back(pay_bytes[offset + i]);
        end
        exp_beats = (eth_hdr_bytes + len_list[idx] + 7) / 8;
        pos = 0;
        beats = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (backpressure) begin
                m_tready = (($urandom % 4) != 0);
            end else begin
                m_tready = 1'b1;
            end
            #1;
            if (m_tvalid && m_tready) begin
                got.tdata = m_tdata;
                got.tkeep = m_tkeep;
                got.tlast = m_tlast;
                got.tuser = m_tuser;
                exp = '0;
                for (int k = 0; k < keep_width; k++) begin
                    if (!m_tkeep[k]) begin
                        got.tdata[8*k +: 8] = 8'h00;
                    end
                    if (pos + k < exp_q.size()) begin
                        exp.tdata[8*k +: 8] = exp_q[pos + k];
                        exp.tkeep[k] = 1'b1;
                    end
                end
                pos += keep_width;
                exp.tlast = (pos >= exp_q.size());
                exp.tuser = exp.tlast && bad_list[idx];
                check_beat($sformatf("frame %0d beat %0d", idx, beats), got, exp);
                beats++;
                done = m_tlast;
            end
        end
        if (beats != exp_beats) begin
            $display("frame %0d ended after %0d beats instead of %0d", idx, beats, exp_beats);
            errors++;
        end
        frames_sent++;
    endtask

    task automatic run_frames(input bit backpressure);
        fork
            for (int i = 0; i < hdr_list.size(); i++) begin
                send_frame(i);
            end
            for (int j = 0; j < hdr_list.size(); j++) begin
                expect_frame(j, backpressure);
            end
        join
        clear_frames();
    endtask

    task automatic verify_reset_state();
        @(negedge clk);
        #1;
        check_bit("hdr_ready after reset", hdr_ready, 1'b0);
        check_bit("s_tready after reset", s_tready, 1'b0);
        check_bit("m_tvalid after reset", m_tvalid, 1'b0);
        check_bit("busy after reset", busy, 1'b0);
        for (int a = 0; a < 4; a++) begin
            cfg_read(cfg_addr_t'(a), rd);
            check_word($sformatf("cfg_rdata reg %0d after reset", a), rd, 32'h0);
        end
    endtask

    task automatic register_access();
        cfg_write(reg_mac_hi, 32'hffff_02a1);
        cfg_write(reg_mac_lo, 32'hb2c3_d4e5);
        cfg_write(reg_ctrl, 32'h0000_0001);
        cfg_write(reg_frame_count, 32'h0000_1234);
        cfg_read(reg_mac_hi, rd);
        check_word("cfg_rdata mac_hi", rd, 32'h0000_02a1);
        cfg_read(reg_mac_lo, rd);
        check_word("cfg_rdata mac_lo", rd, 32'hb2c3_d4e5);
        cfg_read(reg_ctrl, rd);
        check_word("cfg_rdata ctrl", rd, 32'h0000_0001);
        cfg_read(reg_frame_count, rd);
        check_word("cfg_rdata frame_count", rd, 32'h0);
    endtask

    task automatic framing_lengths();
        int lens[6] = '{1, 2, 3, 8, 10, 50};
        foreach (lens[i]) begin
            add_frame(48'h0a1b_2c3d_4e50 + 48'(i), 16'h0800, lens[i], 1'b0);
            run_frames(1'b0);
        end
    endtask

    task automatic random_backpressure();
        repeat (5) begin
            add_frame(48'({$urandom, $urandom}), 16'h86dd, int'(1 + $urandom % 40), 1'b0);
        end
        run_frames(1'b1);
    endtask

    task automatic bad_frame_marking();
        // flush beat, no flush, single byte, then a good frame
        add_frame(48'h5e00_0000_0011, 16'h0806, 5, 1'b1);
        add_frame(48'h5e00_0000_0012, 16'h0806, 10, 1'b1);
        add_frame(48'h5e00_0000_0013, 16'h0806, 1, 1'b1);
        add_frame(48'h5e00_0000_0014, 16'h0806, 9, 1'b0);
        run_frames(1'b1);
    endtask

    task automatic enable_and_count();
        cfg_write(reg_ctrl, 32'h0);
        add_frame(48'h0102_0304_0506, 16'h88b5, 12, 1'b0);
        fork
            send_frame(0);
            begin
                repeat (10) begin
                    @(negedge clk);
                    #1;
                    check_bit("hdr_ready while disabled", hdr_ready, 1'b0);
                    check_bit("m_tvalid while disabled", m_tvalid, 1'b0);
                end
                cfg_write(reg_ctrl, 32'h0000_0001);
                expect_frame(0, 1'b0);
            end
        join
        clear_frames();
        cfg_read(reg_frame_count, rd);
        check_word("cfg_rdata frame_count", rd, cfg_word_t'(frames_sent));
    endtask

    initial begin
        void'($urandom(32'h7ea1_fac6));
        errors = 0;
        frames_sent = 0;
        src_mac_model = '0;
        rst = 1'b1;
        hdr_valid = 1'b0;
        hdr_dest_mac = '0;
        hdr_eth_type = '0;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
        m_tready = 1'b1;
        cfg_addr = reg_ctrl;
        cfg_wdata = '0;
        cfg_we = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        verify_reset_state();
        register_access();
        framing_lengths();
        random_backpressure();
        bad_frame_marking();
        enable_and_count();
        $display("tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* build.f */
common/eth_tx_pkg.sv
common/axis_if.sv
verilog/reg_slice.sv
eth_tx/eth_hdr_insert.sv
eth_tx/tx_cfg_regs.sv
verilog/eth_tx_top.sv
testbench/tb_eth_tx.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 --top-module tb_eth_tx -f build.f

./obj_dir/Vtb_eth_tx | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
grep -q "All tests passed" sim.log
echo "simulation passed"
